/* verilog/fetch_consts.svh */
// fetch front end configuration macros
// line geometry, cache size and bus word width, plus derived field widths
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define FETCH_PC_BITS       32
`define FETCH_LINE_BYTES    16
`define FETCH_SETS          8
`define FETCH_WB_DATA_BITS  32

// derived from the values above
`define FETCH_OFFSET_BITS    ($clog2(`FETCH_LINE_BYTES))
`define FETCH_INDEX_BITS     ($clog2(`FETCH_SETS))
`define FETCH_TAG_BITS       (`FETCH_PC_BITS - `FETCH_INDEX_BITS - `FETCH_OFFSET_BITS)
`define FETCH_WORDS_PER_LINE ((`FETCH_LINE_BYTES * 8) / `FETCH_WB_DATA_BITS)

`endif

/* verilog/fetch_types_pkg.sv */
// fetch side types: fetch address, cache line and the address fields
`default_nettype none

`include "fetch_consts.svh"

package fetch_types_pkg;

  typedef logic [`FETCH_PC_BITS-1:0] pc_t;  // byte address of an instruction fetch

  // word 0 of the line sits in the low bits
  typedef logic [`FETCH_LINE_BYTES*8-1:0] line_t;

  typedef logic [`FETCH_INDEX_BITS-1:0] set_index_t;

  typedef logic [`FETCH_TAG_BITS-1:0] tag_t;  // address bits above the set field

endpackage

`default_nettype wire

/* verilog/wb_types_pkg.sv */
// bus side types: wishbone address and data words, refill FSM states
`default_nettype none

`include "fetch_consts.svh"

package wb_types_pkg;

  typedef logic [`FETCH_PC_BITS-1:0]      wb_addr_t;  // byte address
  typedef logic [`FETCH_WB_DATA_BITS-1:0] wb_data_t;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_BUS,   // word reads in progress
    REFILL_FILL   // line complete, handed to the cache
  } refill_state_t;

endpackage

`default_nettype wire

/* verilog/l0_instruction_cache.sv */
// direct-mapped L0 instruction cache
// same-cycle lookup of hit and line, clocked fill write, flush of all valid bits
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module l0_instruction_cache (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  fetch_types_pkg::pc_t   lookup_pc,
  output logic                   hit,
  output fetch_types_pkg::line_t line,
  input  logic                   fill_valid,
  input  fetch_types_pkg::pc_t   fill_pc,
  input  fetch_types_pkg::line_t fill_line
);

  import fetch_types_pkg::*;

  // arrays, one entry per set
  logic [`FETCH_SETS-1:0] valid_q;
  tag_t                   tag_q  [`FETCH_SETS];
  line_t                  data_q [`FETCH_SETS];

  // address breakdown
  set_index_t lookup_set;
  tag_t       lookup_tag;
  set_index_t fill_set;
  tag_t       fill_tag;

  assign lookup_set = lookup_pc[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
  assign lookup_tag = lookup_pc[`FETCH_PC_BITS-1 -: `FETCH_TAG_BITS];
  assign fill_set   = fill_pc[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
  assign fill_tag   = fill_pc[`FETCH_PC_BITS-1 -: `FETCH_TAG_BITS];

  // lookup has no latency
  assign hit  = valid_q[lookup_set] & (tag_q[lookup_set] == lookup_tag);
  assign line = data_q[lookup_set];

  // valid bits; flush beats a fill landing on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else if (fill_valid) begin
      valid_q[fill_set] <= 1'b1;
    end
  end

  // tag and data are only meaningful behind a set valid bit
  always_ff @(posedge clk) begin
    if (fill_valid) begin
      tag_q[fill_set]  <= fill_tag;
      data_q[fill_set] <= fill_line;  // whole line in one write
    end
  end

endmodule

`default_nettype wire

/* verilog/l0_refill_master.sv */
// line refill over a wishbone classic read master
// four single-word read cycles, assembled into a line and delivered as a fill
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module l0_refill_master (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      refill_req,
  input  fetch_types_pkg::pc_t      refill_pc,
  output logic                      refill_done,
  output logic                      fill_valid,
  output fetch_types_pkg::pc_t      fill_pc,
  output fetch_types_pkg::line_t    fill_line,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output wb_types_pkg::wb_addr_t    wb_adr,
  input  wb_types_pkg::wb_data_t    wb_dat_i,
  input  logic                      wb_ack
);

  import fetch_types_pkg::*;
  import wb_types_pkg::*;

  localparam int BEAT_BITS = $clog2(`FETCH_WORDS_PER_LINE);
  localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(`FETCH_WORDS_PER_LINE - 1);

  refill_state_t         state_q;
  logic                  stb_q;     // a bus cycle is open
  logic                  drop_q;    // flush seen, fill must not land
  logic [BEAT_BITS-1:0]  beat_q;
  pc_t                   base_q;    // line base being fetched
  line_t                 line_q;    // assembled words

  // control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= REFILL_IDLE;
      stb_q   <= 1'b0;
      drop_q  <= 1'b0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        REFILL_IDLE: begin
          if (refill_req) begin
            state_q <= REFILL_BUS;
            stb_q   <= 1'b1;       // first beat goes out next cycle
            drop_q  <= flush;
            beat_q  <= '0;
          end
        end
        REFILL_BUS: begin
          if (flush) begin
            drop_q <= 1'b1;
          end
          if (stb_q) begin
            if (wb_ack) begin
              stb_q <= 1'b0;       // one idle cycle between beats
              if (beat_q == LAST_BEAT) begin
                state_q <= REFILL_FILL;
              end else begin
                beat_q <= beat_q + 1'b1;
              end
            end
          end else begin
            stb_q <= 1'b1;         // next word address
          end
        end
        default: begin             // REFILL_FILL lasts a single cycle
          state_q <= REFILL_IDLE;
          drop_q  <= 1'b0;
        end
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (state_q == REFILL_IDLE && refill_req) begin
      base_q <= refill_pc;
    end
    if (state_q == REFILL_BUS && stb_q && wb_ack) begin
      line_q[beat_q*`FETCH_WB_DATA_BITS +: `FETCH_WB_DATA_BITS] <= wb_dat_i;
    end
  end

  // classic read, cyc and stb move together
  assign wb_cyc = stb_q;
  assign wb_stb = stb_q;
  assign wb_we  = 1'b0;
  assign wb_adr = wb_addr_t'(base_q) + wb_addr_t'({beat_q, 2'b00});

  assign refill_done = (state_q == REFILL_FILL);
  assign fill_valid  = (state_q == REFILL_FILL) & ~drop_q;  // discarded after a flush
  assign fill_pc     = base_q;
  assign fill_line   = line_q;

endmodule

`default_nettype wire

/* verilog/fetch_sequencer.sv */
// fetch address sequencer
// sequential advance, redirects, miss requests and the line output handshake
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_valid,
  input  fetch_types_pkg::pc_t   redirect_pc,
  input  logic                   hit,
  input  fetch_types_pkg::line_t line,
  output fetch_types_pkg::pc_t   lookup_pc,
  output logic                   refill_req,
  output fetch_types_pkg::pc_t   refill_pc,
  input  logic                   refill_done,
  output logic                   fetch_valid,
  input  logic                   fetch_ready,
  output fetch_types_pkg::pc_t   fetch_pc,
  output fetch_types_pkg::line_t fetch_line
);

  import fetch_types_pkg::*;

  localparam pc_t LINE_STEP = pc_t'(`FETCH_LINE_BYTES);
  localparam pc_t LINE_MASK = pc_t'(`FETCH_LINE_BYTES - 1);

  pc_t  pc_q;        // current line base
  pc_t  miss_pc_q;   // line held for the refill in flight
  logic waiting_q;

  assign lookup_pc = pc_q;

  // output is gated while a refill is outstanding
  assign fetch_valid = hit & ~waiting_q;
  assign fetch_pc    = pc_q;
  assign fetch_line  = line;

  // a miss raises the request in the same cycle
  assign refill_req = waiting_q | ~hit;
  assign refill_pc  = waiting_q ? miss_pc_q : pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q      <= '0;
      waiting_q <= 1'b0;
    end else begin
      waiting_q <= refill_req & ~refill_done;
      if (redirect_valid) begin
        pc_q <= redirect_pc & ~LINE_MASK;  // redirect wins over advance
      end else if (fetch_valid && fetch_ready) begin
        pc_q <= pc_q + LINE_STEP;
      end
    end
  end

  // keeps refill_pc stable until done even if pc moves
  always_ff @(posedge clk) begin
    miss_pc_q <= refill_pc;
  end

endmodule

`default_nettype wire

/* verilog/fetch_frontend_top.sv */
// instruction fetch front end top level
// sequencer, L0 cache and wishbone refill master
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_valid,
  input  fetch_types_pkg::pc_t   redirect_pc,
  input  logic                   flush,
  output logic                   fetch_valid,
  output fetch_types_pkg::pc_t   fetch_pc,
  output fetch_types_pkg::line_t fetch_line,
  input  logic                   fetch_ready,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output wb_types_pkg::wb_addr_t wb_adr,
  input  wb_types_pkg::wb_data_t wb_dat_i,
  input  logic                   wb_ack
);

  import fetch_types_pkg::*;

  pc_t   lookup_pc;
  logic  hit;
  line_t line;
  logic  refill_req;
  pc_t   refill_pc;
  logic  refill_done;
  logic  fill_valid;
  pc_t   fill_pc;
  line_t fill_line;

  fetch_sequencer seq_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .hit            (hit),
    .line           (line),
    .lookup_pc      (lookup_pc),
    .refill_req     (refill_req),
    .refill_pc      (refill_pc),
    .refill_done    (refill_done),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .fetch_pc       (fetch_pc),
    .fetch_line     (fetch_line)
  );

  l0_instruction_cache cache_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .lookup_pc  (lookup_pc),
    .hit        (hit),
    .line       (line),
    .fill_valid (fill_valid),
    .fill_pc    (fill_pc),
    .fill_line  (fill_line)
  );

  l0_refill_master refill_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .refill_req  (refill_req),
    .refill_pc   (refill_pc),
    .refill_done (refill_done),
    .fill_valid  (fill_valid),
    .fill_pc     (fill_pc),
    .fill_line   (fill_line),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_ack      (wb_ack)
  );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// testbench clock and reset source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;  // released on the 5th edge
  end

endmodule

`default_nettype wire

/* verif/l1_wb_memory_model.sv */
// wishbone classic read slave standing in for the L1
// registered ack after a random wait, data derived from the address
`timescale 1ns/1ps
`default_nettype none

module l1_wb_memory_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  wb_types_pkg::wb_addr_t wb_adr,
  output wb_types_pkg::wb_data_t wb_dat_o,
  output logic                   wb_ack
);

  import wb_types_pkg::*;

  int unsigned wait_left;  // wait cycles before the next ack

  // rotate left by 7, then xor with a fixed pattern
  function automatic wb_data_t word_at(input wb_addr_t adr);
    return {adr[24:0], adr[31:25]} ^ 32'h5a3c_c3a5;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      wb_dat_o  <= '0;
      wait_left <= 0;
    end else begin
      wb_ack <= 1'b0;  // ack is a single-cycle pulse
      if (wb_cyc && wb_stb && !wb_we && !wb_ack) begin
        if (wait_left == 0) begin
          wb_ack    <= 1'b1;
          wb_dat_o  <= word_at(wb_adr);
          wait_left <= $urandom % 4;  // delay of the following beat
        end else begin
          wait_left <= wait_left - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/fetch_frontend_assertions.sv */
// wishbone protocol and fill pulse assertions for the refill master
// attached to every l0_refill_master by bind
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_assertions (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   wb_cyc,
  input logic                   wb_stb,
  input wb_types_pkg::wb_addr_t wb_adr,
  input logic                   wb_ack,
  input logic                   fill_valid
);

  // failure counts, read by the testbench
  int idle_errors = 0;
  int adr_errors  = 0;
  int fill_errors = 0;

  // cyc and stb drop for one cycle after each ack
  idle_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && wb_ack) |=> (!wb_cyc && !wb_stb))
    else begin
      idle_errors++;
      $error("wishbone cycle still open on the cycle after ack");
    end

  // request held with a stable address until the slave acks
  adr_held: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else begin
      adr_errors++;
      $error("wishbone request dropped or address moved before ack");
    end

  fill_pulse: assert property (@(posedge clk) disable iff (!rst_n) fill_valid |=> !fill_valid)
    else begin
      fill_errors++;
      $error("fill_valid high for more than one cycle");
    end

endmodule

bind l0_refill_master fetch_frontend_assertions refill_checks_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .wb_cyc     (wb_cyc),
  .wb_stb     (wb_stb),
  .wb_adr     (wb_adr),
  .wb_ack     (wb_ack),
  .fill_valid (fill_valid)
);

`default_nettype wire

/* verif/fetch_frontend_tb.sv */
// testbench for the fetch front end: random redirect, flush and stall stimulus,
// reference model of the fetch address and cache contents, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_frontend_tb;

  import fetch_types_pkg::*;
  import wb_types_pkg::*;

  localparam int  RUN_CYCLES  = 3000;
  localparam int  WATCHDOG_NS = RUN_CYCLES * 10 * 2 + 5 * 10;
  localparam pc_t LINE_STEP   = pc_t'(`FETCH_LINE_BYTES);
  localparam pc_t LINE_MASK   = pc_t'(`FETCH_LINE_BYTES - 1);

  logic     clk;
  logic     rst_n;
  logic     redirect_valid = 1'b0;
  pc_t      redirect_pc    = '0;
  logic     flush          = 1'b0;
  logic     fetch_ready    = 1'b0;
  logic     fetch_valid;
  pc_t      fetch_pc;
  line_t    fetch_line;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat;
  logic     wb_ack;

  // reference model state
  pc_t        exp_pc = '0;
  logic       mirror_valid [`FETCH_SETS] = '{default: 1'b0};
  pc_t        mirror_base  [`FETCH_SETS] = '{default: '0};
  logic       inflight     = 1'b0;  // refill requested and not yet done
  logic       was_inflight = 1'b0;
  logic       dropped      = 1'b0;  // a flush hit the refill in flight
  logic       fill_pending = 1'b0;  // all words read, fill lands on the next edge
  pc_t        refill_base  = '0;
  int         beats        = 0;
  logic       exp_hit;
  logic       exp_fv;
  set_index_t look_set;
  set_index_t fill_set;
  logic       hold_seen    = 1'b0;
  pc_t        hold_pc;
  line_t      hold_line;
  int         errors       = 0;
  int         transfers    = 0;
  int         refills      = 0;

  tb_clock_gen clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  l1_wb_memory_model l1_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat),
    .wb_ack   (wb_ack)
  );

  fetch_frontend_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .flush          (flush),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_line     (fetch_line),
    .fetch_ready    (fetch_ready),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_i       (wb_dat),
    .wb_ack         (wb_ack)
  );

  function automatic wb_data_t mem_word(input wb_addr_t adr);
    return {adr[24:0], adr[31:25]} ^ 32'h5a3c_c3a5;
  endfunction

  function automatic line_t expected_line(input pc_t base);
    line_t l;
    for (int w = 0; w < `FETCH_WORDS_PER_LINE; w++) begin
      l[w*`FETCH_WB_DATA_BITS +: `FETCH_WB_DATA_BITS] = mem_word(base + pc_t'(w * 4));
    end
    return l;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // sample at the edge, update the model, then drive the next inputs
  always @(posedge clk) begin
    if (rst_n) begin
      look_set     = exp_pc[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
      exp_hit      = mirror_valid[look_set] && (mirror_base[look_set] == exp_pc);
      exp_fv       = exp_hit && !inflight;
      was_inflight = inflight;

      if (fetch_valid !== exp_fv) begin
        flag_error($sformatf("fetch_valid %0b, expected %0b at pc %h", fetch_valid, exp_fv, exp_pc));
      end
      if (fetch_valid && fetch_ready) begin
        transfers++;
        if (fetch_pc !== exp_pc) begin
          flag_error($sformatf("fetch_pc %h, expected %h", fetch_pc, exp_pc));
        end
        if (fetch_line !== expected_line(exp_pc)) begin
          flag_error($sformatf("line at %h is %h", exp_pc, fetch_line));
        end
      end

      // stalled output must hold
      if (hold_seen && (fetch_pc !== hold_pc || fetch_line !== hold_line)) begin
        flag_error($sformatf("stalled output moved from pc %h to %h", hold_pc, fetch_pc));
      end
      hold_seen = fetch_valid && !fetch_ready && !redirect_valid;
      hold_pc   = fetch_pc;
      hold_line = fetch_line;

      if (wb_we !== 1'b0) begin
        flag_error("wishbone we raised by a read-only master");
      end
      if (wb_cyc && !inflight) begin
        flag_error($sformatf("wishbone cycle at %h with no miss outstanding", wb_adr));
      end
      if (inflight) begin
        dropped = dropped | flush;
        if (fill_pending) begin
          if (!dropped) begin
            fill_set               = refill_base[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
            mirror_valid[fill_set] = 1'b1;
            mirror_base[fill_set]  = refill_base;
          end
          inflight     = 1'b0;
          fill_pending = 1'b0;
        end else if (wb_cyc && wb_stb && wb_ack) begin
          if (wb_adr !== refill_base + wb_addr_t'(beats * 4)) begin
            flag_error($sformatf("refill beat %0d read %h, line base %h", beats, wb_adr,
                                 refill_base));
          end
          beats++;
          if (beats == `FETCH_WORDS_PER_LINE) begin
            fill_pending = 1'b1;
          end
        end
      end
      if (flush) begin
        for (int s = 0; s < `FETCH_SETS; s++) begin
          mirror_valid[s] = 1'b0;
        end
      end

      // a miss with no refill outstanding starts one for the current line
      if (!was_inflight && !exp_hit) begin
        inflight    = 1'b1;
        dropped     = flush;
        refill_base = exp_pc;
        beats       = 0;
        refills++;
      end

      if (redirect_valid) begin
        exp_pc = redirect_pc & ~LINE_MASK;
      end else if (exp_fv && fetch_ready) begin
        exp_pc = exp_pc + LINE_STEP;
      end

      redirect_valid <= ($urandom % 8) == 0;
      redirect_pc    <= pc_t'($urandom % 512);  // small window so lines come back
      flush          <= ($urandom % 64) == 0;
      fetch_ready    <= ($urandom % 4) != 0;
    end
  end

  initial begin
    int assert_fails;
    int total;
    void'($urandom(32'h12d5));
    @(posedge rst_n);
    repeat (RUN_CYCLES) @(posedge clk);
    #1;
    assert_fails = dut_i.refill_i.refill_checks_i.idle_errors
                 + dut_i.refill_i.refill_checks_i.adr_errors
                 + dut_i.refill_i.refill_checks_i.fill_errors;
    total = errors + assert_fails;
    if (transfers == 0 || refills == 0) begin
      $display("the run transferred no line or started no refill");
      total++;
    end
    $display("summary: %0d transfers, %0d refills, %0d check errors, %0d assertion failures",
             transfers, refills, errors, assert_fails);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/fetch_types_pkg.sv
verilog/wb_types_pkg.sv
verilog/l0_instruction_cache.sv
verilog/l0_refill_master.sv
verilog/fetch_sequencer.sv
verilog/fetch_frontend_top.sv
verif/tb_clock_gen.sv
verif/l1_wb_memory_model.sv
verif/fetch_frontend_assertions.sv
verif/fetch_frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fetch front end testbench with Verilator, run it, check the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module fetch_frontend_tb -Mdir "$OBJ" -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vfetch_frontend_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
